/* src/cache_pkg.sv */
package cache_pkg;

    // ####################
    // Main memory geometry
    // ####################

    localparam int mem_words     = 8192;
    localparam int mem_addr_bits = $clog2(mem_words);

    // ####################
    // Cache geometry
    // ####################

    localparam int words_per_line = 4;
    localparam int offset_bits    = $clog2(words_per_line);
    localparam int num_lines      = 16;
    localparam int index_bits     = $clog2(num_lines);
    localparam int tag_bits       = mem_addr_bits - index_bits - offset_bits;
    localparam int line_bits      = 32 * words_per_line;

    // Latencies are counted from the edge that first samples mem_req high.
    localparam int mem_read_delay  = 10;
    localparam int mem_write_delay = 8;

    localparam logic [31:0] mem_init_xor = 32'h5A00_0000;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_fill,
        st_write,
        st_ack
    } ctrl_state_t;

    // Power-up contents of the word at address addr.
    function automatic logic [31:0] mem_init_word(input logic [31:0] addr);
        return addr ^ mem_init_xor;
    endfunction

endpackage

/* src/tag_store.sv */
`timescale 1ns/1ps

module tag_store (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [cache_pkg::index_bits-1:0] index,
    input  logic [cache_pkg::tag_bits-1:0]   tag,
    input  logic                             tag_write,
    output logic                             hit
);

    logic [cache_pkg::num_lines-1:0] valid;
    logic [cache_pkg::tag_bits-1:0]  tags [cache_pkg::num_lines];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= '0;
        end else if (tag_write) begin
            valid[index] <= 1'b1;
        end
    end

    // A fill writes the new tag of its line together with the valid bit.
    always_ff @(posedge clk) begin
        if (tag_write) begin
            tags[index] <= tag;
        end
    end

    assign hit = valid[index] && (tags[index] == tag);

endmodule

/* src/line_store.sv */
`timescale 1ns/1ps

module line_store (
    input  logic                              clk,
    input  logic [cache_pkg::index_bits-1:0]  index,
    input  logic [cache_pkg::offset_bits-1:0] word_offset,
    input  logic                              line_fill,
    input  logic [cache_pkg::line_bits-1:0]   fill_line,
    input  logic                              word_write,
    input  logic [31:0]                       wdata,
    output logic [31:0]                       rd_word
);

    logic [cache_pkg::line_bits-1:0] lines [cache_pkg::num_lines];

    // A fill replaces the whole line. A write hit patches one word.
    always_ff @(posedge clk) begin
        if (line_fill) begin
            lines[index] <= fill_line;
        end else if (word_write) begin
            lines[index][word_offset*32 +: 32] <= wdata;
        end
    end

    // Word 0 sits in the low bits of the line.
    assign rd_word = lines[index][word_offset*32 +: 32];

endmodule

/* src/main_mem.sv */
`timescale 1ns/1ps

module main_mem (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            mem_req,
    input  logic                            mem_we,
    input  logic [31:0]                     mem_addr,
    input  logic [31:0]                     mem_wdata,
    output logic [cache_pkg::line_bits-1:0] mem_line,
    output logic                            mem_ready
);

    typedef logic [$clog2(cache_pkg::mem_read_delay)-1:0] count_t;

    logic [31:0] mem [cache_pkg::mem_words];

    logic   busy;
    logic   done;
    logic   expire;
    count_t count;

    logic [cache_pkg::mem_addr_bits-1:0] word_addr;
    logic [cache_pkg::mem_addr_bits-cache_pkg::offset_bits-1:0] line_addr;

    initial begin
        for (int a = 0; a < cache_pkg::mem_words; a++) begin
            mem[a] = cache_pkg::mem_init_word(32'(a));
        end
    end

    assign word_addr = mem_addr[cache_pkg::mem_addr_bits-1:0];
    assign line_addr = mem_addr[cache_pkg::mem_addr_bits-1:cache_pkg::offset_bits];
    assign expire    = busy && (count == '0);

    // ####################
    // Latency sequencing
    // ####################

    // After a completion the model waits for mem_req to go low first.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            count     <= '0;
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= 1'b0;
            if (busy) begin
                if (expire) begin
                    busy      <= 1'b0;
                    done      <= 1'b1;
                    mem_ready <= 1'b1;
                end else begin
                    count <= count - 1'b1;
                end
            end else if (done) begin
                if (!mem_req) begin
                    done <= 1'b0;
                end
            end else if (mem_req) begin
                busy  <= 1'b1;
                count <= mem_we ? count_t'(cache_pkg::mem_write_delay - 1) :
                                  count_t'(cache_pkg::mem_read_delay - 1);
            end
        end
    end

    // ####################
    // Storage access
    // ####################

    always_ff @(posedge clk) begin
        if (expire) begin
            if (mem_we) begin
                mem[word_addr] <= mem_wdata;
            end else begin
                for (int i = 0; i < cache_pkg::words_per_line; i++) begin
                    mem_line[i*32 +: 32] <= mem[{line_addr, cache_pkg::offset_bits'(i)}];
                end
            end
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst)
        busy |=> $stable(mem_addr))
        else $error("error: mem_addr changed during access, mem_addr=%h", mem_addr);

endmodule

/* src/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cpu_req,
    input  logic                             cpu_we,
    input  logic [31:0]                      cpu_addr,
    input  logic [31:0]                      cpu_wdata,
    input  logic                             hit,
    input  logic                             mem_ready,
    output logic                             cpu_ack,
    output logic [cache_pkg::index_bits-1:0] index,
    output logic [cache_pkg::tag_bits-1:0]   tag,
    output logic                             tag_write,
    output logic                             line_fill,
    output logic                             word_write,
    output logic [cache_pkg::offset_bits-1:0] word_offset,
    output logic                             mem_req,
    output logic                             mem_we,
    output logic [31:0]                      mem_addr,
    output logic [31:0]                      mem_wdata
);

    cache_pkg::ctrl_state_t state;

    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic        we_q;
    logic        fill_done;

    // The request is captured once and held until the transaction ends.
    always_ff @(posedge clk) begin
        if (state == cache_pkg::st_idle && cpu_req) begin
            addr_q  <= cpu_addr;
            wdata_q <= cpu_wdata;
            we_q    <= cpu_we;
        end
    end

    // The address splits into offset, index and tag. Bits above the memory size are dropped.
    assign word_offset = addr_q[cache_pkg::offset_bits-1:0];
    assign index       = addr_q[cache_pkg::offset_bits +: cache_pkg::index_bits];
    assign tag         = addr_q[cache_pkg::offset_bits + cache_pkg::index_bits +:
                                cache_pkg::tag_bits];

    // Reads fetch the whole aligned line. Writes go out as a single word.
    assign mem_we    = we_q;
    assign mem_wdata = wdata_q;
    assign mem_addr  = we_q ? addr_q :
                       {addr_q[31:cache_pkg::offset_bits], {cache_pkg::offset_bits{1'b0}}};

    assign fill_done  = (state == cache_pkg::st_fill) && mem_ready;
    assign line_fill  = fill_done;
    assign tag_write  = fill_done;
    assign word_write = (state == cache_pkg::st_write) && mem_ready && hit;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= cache_pkg::st_idle;
            cpu_ack <= 1'b0;
            mem_req <= 1'b0;
        end else begin
            case (state)
                cache_pkg::st_idle: begin
                    if (cpu_req) begin
                        state <= cache_pkg::st_lookup;
                    end
                end
                cache_pkg::st_lookup: begin
                    if (we_q) begin
                        mem_req <= 1'b1;
                        state   <= cache_pkg::st_write;
                    end else if (hit) begin
                        state <= cache_pkg::st_ack;
                    end else begin
                        mem_req <= 1'b1;
                        state   <= cache_pkg::st_fill;
                    end
                end
                // After the fill the lookup runs again and now hits.
                cache_pkg::st_fill: begin
                    if (mem_ready) begin
                        mem_req <= 1'b0;
                        state   <= cache_pkg::st_lookup;
                    end
                end
                cache_pkg::st_write: begin
                    if (mem_ready) begin
                        mem_req <= 1'b0;
                        state   <= cache_pkg::st_ack;
                    end
                end
                cache_pkg::st_ack: begin
                    if (cpu_req) begin
                        cpu_ack <= 1'b1;
                    end else begin
                        cpu_ack <= 1'b0;
                        state   <= cache_pkg::st_idle;
                    end
                end
                default: state <= cache_pkg::st_idle;
            endcase
        end
    end

    a_mem_req_held: assert property (@(posedge clk) disable iff (!rst)
        mem_req && !mem_ready |=> mem_req)
        else $error("error: mem_req dropped before mem_ready, mem_addr=%h", mem_addr);

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst)
        $rose(cpu_ack) |-> $past(cpu_req))
        else $error("error: cpu_ack rose with cpu_req low, cpu_addr=%h", cpu_addr);

endmodule

/* src/cache_top.sv */
`timescale 1ns/1ps

module cache_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_req,
    input  logic        cpu_we,
    input  logic [31:0] cpu_addr,
    input  logic [31:0] cpu_wdata,
    output logic [31:0] cpu_rdata,
    output logic        cpu_ack
);

    logic [cache_pkg::index_bits-1:0]  index;
    logic [cache_pkg::tag_bits-1:0]    tag;
    logic [cache_pkg::offset_bits-1:0] word_offset;
    logic                              tag_write;
    logic                              line_fill;
    logic                              word_write;
    logic                              hit;

    logic                            mem_req;
    logic                            mem_we;
    logic [31:0]                     mem_addr;
    logic [31:0]                     mem_wdata;
    logic [cache_pkg::line_bits-1:0] mem_line;
    logic                            mem_ready;

    cache_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .cpu_we      (cpu_we),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .hit         (hit),
        .mem_ready   (mem_ready),
        .cpu_ack     (cpu_ack),
        .index       (index),
        .tag         (tag),
        .tag_write   (tag_write),
        .line_fill   (line_fill),
        .word_write  (word_write),
        .word_offset (word_offset),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata)
    );

    tag_store u_tags (
        .clk       (clk),
        .rst       (rst),
        .index     (index),
        .tag       (tag),
        .tag_write (tag_write),
        .hit       (hit)
    );

    // Write hits take their data from the same word sent to memory.
    line_store u_lines (
        .clk         (clk),
        .index       (index),
        .word_offset (word_offset),
        .line_fill   (line_fill),
        .fill_line   (mem_line),
        .word_write  (word_write),
        .wdata       (mem_wdata),
        .rd_word     (cpu_rdata)
    );

    main_mem u_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_line  (mem_line),
        .mem_ready (mem_ready)
    );

endmodule

/* tests/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

    localparam int          ack_timeout = 200;
    localparam int          random_ops  = 200;
    localparam logic [31:0] addr_mask   = 32'h0000_00FF;
    // A hit acks on the third edge counted from the one that first sees cpu_req.
    localparam int          hit_edges   = 3;

    logic        clk;
    logic        rst;
    logic        cpu_req;
    logic        cpu_we;
    logic [31:0] cpu_addr;
    logic [31:0] cpu_wdata;
    logic [31:0] cpu_rdata;
    logic        cpu_ack;

    int data_errors;
    int timing_errors;
    int handshake_errors;
    int timeout_errors;
    bit aborted;
    int req_edges;

    logic [31:0] rng_state;
    logic [31:0] model_mem [int];
    logic        shadow_valid [cache_pkg::num_lines];
    logic [cache_pkg::tag_bits-1:0] shadow_tag [cache_pkg::num_lines];

    logic        exp_we;
    logic        exp_hit;
    logic [31:0] exp_data;

    cache_top uut (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .cpu_ack   (cpu_ack)
    );

    always #4 clk = ~clk;

    // Edges seen while a request waits for its ack.
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_edges <= 0;
        end else if (!cpu_req) begin
            req_edges <= 0;
        end else if (!cpu_ack) begin
            req_edges <= req_edges + 1;
        end
    end

    // ####################
    // Checks
    // ####################

    a_read_data: assert property (@(posedge clk) disable iff (!rst)
        cpu_ack && !exp_we |-> cpu_rdata == exp_data)
        else begin
            data_errors++;
            $display("error: cpu_rdata=%h expected %h, cpu_addr=%h",
                     $sampled(cpu_rdata), exp_data, cpu_addr);
        end

    a_hit_latency: assert property (@(posedge clk) disable iff (!rst)
        $rose(cpu_ack) && exp_hit |-> req_edges == hit_edges)
        else begin
            timing_errors++;
            $display("error: req_edges=%h expected %h on a hit, cpu_addr=%h",
                     $sampled(req_edges), hit_edges, cpu_addr);
        end

    a_miss_latency: assert property (@(posedge clk) disable iff (!rst)
        $rose(cpu_ack) && !exp_hit |-> req_edges > hit_edges)
        else begin
            timing_errors++;
            $display("error: req_edges=%h on a miss or write, cpu_addr=%h",
                     $sampled(req_edges), cpu_addr);
        end

    a_ack_rise: assert property (@(posedge clk) disable iff (!rst)
        $rose(cpu_ack) |-> $past(cpu_req))
        else begin
            handshake_errors++;
            $display("cpu_ack rose while cpu_req was low");
        end

    a_ack_fall: assert property (@(posedge clk) disable iff (!rst)
        $fell(cpu_ack) |-> !$past(cpu_req))
        else begin
            handshake_errors++;
            $display("cpu_ack dropped while cpu_req was still high");
        end

    a_ack_hold: assert property (@(posedge clk) disable iff (!rst)
        cpu_ack && cpu_req |=> cpu_ack)
        else begin
            handshake_errors++;
            $display("cpu_ack dropped although cpu_req was held high");
        end

    // ####################
    // Stimulus helpers
    // ####################

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    // Unwritten words still hold their power-up value.
    function automatic logic [31:0] model_read(input logic [31:0] addr);
        int key;
        key = int'(addr[cache_pkg::mem_addr_bits-1:0]);
        if (model_mem.exists(key)) begin
            return model_mem[key];
        end
        return 32'(key) ^ cache_pkg::mem_init_xor;
    endfunction

    task automatic wait_ack(input logic level, input string what);
        int n;
        n = 0;
        while (cpu_ack !== level && n < ack_timeout) begin
            @(negedge clk);
            n++;
        end
        if (cpu_ack !== level) begin
            $display("timeout: cpu_ack did not %s within %0d cycles, cpu_addr=%h",
                     what, ack_timeout, cpu_addr);
            timeout_errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic cpu_access(input logic we, input logic [31:0] addr,
                              input logic [31:0] data, input int hold);
        logic [cache_pkg::index_bits-1:0] idx;
        logic [cache_pkg::tag_bits-1:0]   tg;
        if (aborted) begin
            return;
        end
        idx = addr[cache_pkg::offset_bits +: cache_pkg::index_bits];
        tg  = addr[cache_pkg::offset_bits + cache_pkg::index_bits +: cache_pkg::tag_bits];
        exp_we = we;
        if (we) begin
            // No write allocate, so the shadow tags stay as they are.
            exp_hit  = 1'b0;
            exp_data = data;
            model_mem[int'(addr[cache_pkg::mem_addr_bits-1:0])] = data;
        end else begin
            exp_hit           = shadow_valid[idx] && shadow_tag[idx] == tg;
            exp_data          = model_read(addr);
            shadow_valid[idx] = 1'b1;
            shadow_tag[idx]   = tg;
        end
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_wdata = data;
        cpu_req   = 1'b1;
        wait_ack(1'b1, "rise");
        repeat (hold) @(negedge clk);
        cpu_req = 1'b0;
        wait_ack(1'b0, "fall");
    endtask

    // ####################
    // Main sequence
    // ####################

    initial begin
        logic [31:0] r;
        clk       = 1'b0;
        rst       = 1'b0;
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        exp_we    = 1'b0;
        exp_hit   = 1'b0;
        exp_data  = '0;
        rng_state = 32'd8472;
        for (int i = 0; i < cache_pkg::num_lines; i++) begin
            shadow_valid[i] = 1'b0;
            shadow_tag[i]   = '0;
        end
        repeat (2) @(negedge clk);
        rst = 1'b1;
        assert (cpu_ack === 1'b0) else begin
            handshake_errors++;
            $display("error: cpu_ack=%h after reset, expected 0", cpu_ack);
        end

        // Cold miss, then hits within the same line.
        cpu_access(1'b0, 32'h010, 32'h0, 0);
        cpu_access(1'b0, 32'h010, 32'h0, 0);
        cpu_access(1'b0, 32'h013, 32'h0, 0);
        // Write hit on a cached line, then a write to an uncached line.
        cpu_access(1'b1, 32'h011, 32'hCAFE_0011, 0);
        cpu_access(1'b0, 32'h011, 32'h0, 0);
        cpu_access(1'b1, 32'h0A5, 32'hBEEF_00A5, 0);
        cpu_access(1'b0, 32'h0A5, 32'h0, 0);
        // Same index, different tags.
        cpu_access(1'b0, 32'h020, 32'h0, 0);
        cpu_access(1'b0, 32'h220, 32'h0, 0);
        cpu_access(1'b0, 32'h020, 32'h0, 0);
        cpu_access(1'b0, 32'h220, 32'h0, 0);
        cpu_access(1'b0, 32'h010, 32'h0, 5);

        for (int i = 0; i < random_ops; i++) begin
            r = next_rand();
            cpu_access(r[20], (next_rand() >> 8) & addr_mask, next_rand(), int'(r[25:24]));
        end

        repeat (4) @(negedge clk);
        $display("errors: data %0d, timing %0d, handshake %0d, timeout %0d",
                 data_errors, timing_errors, handshake_errors, timeout_errors);
        if (data_errors + timing_errors + handshake_errors + timeout_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* sources.f */
src/cache_pkg.sv
src/tag_store.sv
src/line_store.sv
src/main_mem.sv
src/cache_ctrl.sv
src/cache_top.sv
tests/cache_tb.sv

/* Makefile */
VERILATOR   ?= verilator
TOP         ?= cache_tb
FILELIST    ?= sources.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --assert -Wno-fatal
LINT_FLAGS  ?= --lint-only --timing -Wall
PASS_TEXT   ?= *** PASSED ***

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
